// File: src/z80_consts.svh
//////////////////////////////////////////////////////////////////////
// r-field and ALU op codes follow the Z80 opcode map for 10 ooo rrr.
// registers come out of reset with the fixed values below.
//////////////////////////////////////////////////////////////////////
`ifndef Z80_CONSTS_SVH
`define Z80_CONSTS_SVH

// r field.
`define Z80_REG_B 3'd0
`define Z80_REG_C 3'd1
`define Z80_REG_D 3'd2
`define Z80_REG_E 3'd3
`define Z80_REG_H 3'd4
`define Z80_REG_L 3'd5
`define Z80_REG_M 3'd6
`define Z80_REG_A 3'd7

// op field.
`define Z80_ALU_ADD 3'd0
`define Z80_ALU_ADC 3'd1
`define Z80_ALU_SUB 3'd2
`define Z80_ALU_SBC 3'd3
`define Z80_ALU_AND 3'd4
`define Z80_ALU_XOR 3'd5
`define Z80_ALU_OR  3'd6
`define Z80_ALU_CP  3'd7

// flag bit positions in F.
`define Z80_FLAG_S_BIT 7
`define Z80_FLAG_Z_BIT 6
`define Z80_FLAG_5_BIT 5
`define Z80_FLAG_H_BIT 4
`define Z80_FLAG_3_BIT 3
`define Z80_FLAG_V_BIT 2
`define Z80_FLAG_N_BIT 1
`define Z80_FLAG_C_BIT 0

`define Z80_RESET_A  8'h00
`define Z80_RESET_B  8'h3c
`define Z80_RESET_C  8'ha7
`define Z80_RESET_D  8'h01
`define Z80_RESET_E  8'h80
`define Z80_RESET_H  8'h7f
`define Z80_RESET_L  8'hff
`define Z80_RESET_F  8'h00
`define Z80_RESET_IP 16'h0000

`define Z80_CNT_W 16

`endif

// File: src/z80_pkg.sv
//////////////////////////////////////////////////////////////////////
// types shared by the core, the spec block and the monitor.
//////////////////////////////////////////////////////////////////////
`include "z80_consts.svh"

package z80_pkg;

    typedef enum logic [2:0] {
        ALU_ADD = `Z80_ALU_ADD,
        ALU_ADC = `Z80_ALU_ADC,
        ALU_SUB = `Z80_ALU_SUB,
        ALU_SBC = `Z80_ALU_SBC,
        ALU_AND = `Z80_ALU_AND,
        ALU_XOR = `Z80_ALU_XOR,
        ALU_OR  = `Z80_ALU_OR,
        ALU_CP  = `Z80_ALU_CP
    } alu_func_e;

    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        HALT
    } seq_state_e;

    // 80 bits.
    typedef struct packed {
        logic [7:0]  a;
        logic [7:0]  b;
        logic [7:0]  c;
        logic [7:0]  d;
        logic [7:0]  e;
        logic [7:0]  h;
        logic [7:0]  l;
        logic [7:0]  f;
        logic [15:0] ip;
    } regs_t;

    typedef struct packed {
        logic [7:0]            insn;
        logic [`Z80_CNT_W-1:0] order;
        regs_t                 regs_in;
        logic [7:0]            a_out;
        logic [7:0]            f_out;
        logic [15:0]           ip_out;
    } trace_t;

    typedef struct packed {
        logic        valid;
        logic [7:0]  a_out;
        logic [7:0]  f_out;
        logic [15:0] ip_out;
    } spec_t;

endpackage

// File: src/z80_seq_fsm.sv
//////////////////////////////////////////////////////////////////////
// read-only wishbone classic fetch, one byte per instruction.
// any opcode outside ALU A,r (r != 6) halts until reset.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "z80_consts.svh"

module z80_seq_fsm (
    input  logic        clk,
    input  logic        rst_n,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic [15:0] wb_adr,
    input  logic [7:0]  wb_dat,
    input  logic        wb_ack,
    input  logic [15:0] ip,
    output logic [7:0]  insn,
    output logic        commit,
    output logic        halted
);
    import z80_pkg::*;

    seq_state_e state;
    logic       cyc_q;
    logic       legal;
    logic [7:0] insn_q;

    // group 10 ooo rrr, no memory operand.
    assign legal = (wb_dat[7:6] == 2'b10) && (wb_dat[2:0] != `Z80_REG_M);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= FETCH;
            cyc_q <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    if (cyc_q && wb_ack) begin
                        cyc_q <= 1'b0;
                        state <= legal ? EXEC : HALT;
                    end else begin
                        cyc_q <= 1'b1;
                    end
                end
                EXEC: begin
                    // next fetch starts right after commit.
                    state <= FETCH;
                    cyc_q <= 1'b1;
                end
                HALT: begin
                    cyc_q <= 1'b0;
                end
                default: begin
                    state <= HALT;
                    cyc_q <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cyc_q && wb_ack) begin
            insn_q <= wb_dat;
        end
    end

    assign wb_cyc = cyc_q;
    assign wb_stb = cyc_q;
    assign wb_adr = ip;
    assign insn   = insn_q;
    assign commit = (state == EXEC);
    assign halted = (state == HALT);

endmodule

// File: src/z80_regfile.sv
//////////////////////////////////////////////////////////////////////
// only A, F and IP change; B..L keep their reset values.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "z80_consts.svh"

module z80_regfile (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [7:0]            insn,
    input  logic                  commit,
    input  logic [7:0]            alu_result,
    input  logic [7:0]            alu_flags,
    output z80_pkg::regs_t        regs,
    output logic [7:0]            operand,
    output logic [15:0]           ip,
    output logic                  trace_valid,
    output z80_pkg::trace_t       trace,
    input  logic [`Z80_CNT_W-1:0] order
);
    import z80_pkg::*;

    regs_t      regs_q;
    logic       is_cp;
    logic [7:0] a_next;

    assign is_cp  = (insn[5:3] == `Z80_ALU_CP);
    assign a_next = is_cp ? regs_q.a : alu_result;

    always_comb begin
        case (insn[2:0])
            `Z80_REG_B: operand = regs_q.b;
            `Z80_REG_C: operand = regs_q.c;
            `Z80_REG_D: operand = regs_q.d;
            `Z80_REG_E: operand = regs_q.e;
            `Z80_REG_H: operand = regs_q.h;
            `Z80_REG_L: operand = regs_q.l;
            `Z80_REG_A: operand = regs_q.a;
            default:    operand = 8'h00;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs_q.a  <= `Z80_RESET_A;
            regs_q.b  <= `Z80_RESET_B;
            regs_q.c  <= `Z80_RESET_C;
            regs_q.d  <= `Z80_RESET_D;
            regs_q.e  <= `Z80_RESET_E;
            regs_q.h  <= `Z80_RESET_H;
            regs_q.l  <= `Z80_RESET_L;
            regs_q.f  <= `Z80_RESET_F;
            regs_q.ip <= `Z80_RESET_IP;
        end else if (commit) begin
            regs_q.a  <= a_next;
            regs_q.f  <= alu_flags;
            regs_q.ip <= regs_q.ip + 16'd1;
        end
    end

    assign regs = regs_q;
    assign ip   = regs_q.ip;

    // trace shows the state before this commit and the values it writes.
    assign trace_valid   = commit;
    assign trace.insn    = insn;
    assign trace.order   = order;
    assign trace.regs_in = regs_q;
    assign trace.a_out   = a_next;
    assign trace.f_out   = alu_flags;
    assign trace.ip_out  = regs_q.ip + 16'd1;

endmodule

// File: src/z80_alu.sv
//////////////////////////////////////////////////////////////////////
// single adder path; subtraction adds the inverted operand.
// flags 5 and 3 are not modelled and pass through from f_in.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "z80_consts.svh"

module z80_alu (
    input  z80_pkg::alu_func_e op,
    input  logic [7:0]         a,
    input  logic [7:0]         operand,
    input  logic [7:0]         f_in,
    output logic [7:0]         result,
    output logic [7:0]         f_out
);
    import z80_pkg::*;

    logic       is_sub;
    logic       is_logic;
    logic       cin;
    logic [7:0] b_eff;
    logic [8:0] sum9;
    logic [4:0] sum5;
    logic [7:0] logic_res;
    logic       flag_h;
    logic       flag_v;
    logic       flag_c;

    assign is_sub   = (op == ALU_SUB) || (op == ALU_SBC) || (op == ALU_CP);
    assign is_logic = (op == ALU_AND) || (op == ALU_XOR) || (op == ALU_OR);

    // a - b - c computed as a + ~b + !c.
    assign cin   = is_sub ^ (((op == ALU_ADC) || (op == ALU_SBC)) && f_in[`Z80_FLAG_C_BIT]);
    assign b_eff = is_sub ? ~operand : operand;
    assign sum9  = {1'b0, a} + {1'b0, b_eff} + {8'd0, cin};
    assign sum5  = {1'b0, a[3:0]} + {1'b0, b_eff[3:0]} + {4'd0, cin};

    always_comb begin
        case (op)
            ALU_AND: logic_res = a & operand;
            ALU_XOR: logic_res = a ^ operand;
            default: logic_res = a | operand;
        endcase
    end

    assign result = is_logic ? logic_res : sum9[7:0];

    // carry out of the adder is inverted borrow when subtracting.
    assign flag_c = is_logic ? 1'b0 : (sum9[8] ^ is_sub);
    assign flag_h = is_logic ? (op == ALU_AND) : (sum5[4] ^ is_sub);
    assign flag_v = is_logic ? ~^result : ((a[7] == b_eff[7]) && (sum9[7] != a[7]));

    always_comb begin
        f_out                  = 8'h00;
        f_out[`Z80_FLAG_S_BIT] = result[7];
        f_out[`Z80_FLAG_Z_BIT] = (result == 8'h00);
        f_out[`Z80_FLAG_5_BIT] = f_in[`Z80_FLAG_5_BIT];
        f_out[`Z80_FLAG_H_BIT] = flag_h;
        f_out[`Z80_FLAG_3_BIT] = f_in[`Z80_FLAG_3_BIT];
        f_out[`Z80_FLAG_V_BIT] = flag_v;
        f_out[`Z80_FLAG_N_BIT] = is_sub;
        f_out[`Z80_FLAG_C_BIT] = flag_c;
    end

endmodule

// File: src/z80fi_insn_spec_alu_a_reg.sv
//////////////////////////////////////////////////////////////////////
// reference rules for ADD/ADC/SUB/SBC/AND/XOR/OR/CP A,r.
// only valid for one-byte opcodes with r != 6.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "z80_consts.svh"

module z80fi_insn_spec_alu_a_reg (
    input  logic            trace_valid,
    input  z80_pkg::trace_t trace,
    output z80_pkg::spec_t  spec
);
    import z80_pkg::*;

    logic [2:0] op;
    logic [2:0] r;
    logic [7:0] a_in;
    logic [7:0] operand;
    logic       carry_in;
    logic       is_sub;
    logic       is_logical;
    logic [8:0] wide;
    logic [4:0] half;
    logic [7:0] result;
    logic       flag_v;

    assign op   = trace.insn[5:3];
    assign r    = trace.insn[2:0];
    assign a_in = trace.regs_in.a;

    always_comb begin
        case (r)
            `Z80_REG_A: operand = trace.regs_in.a;
            `Z80_REG_B: operand = trace.regs_in.b;
            `Z80_REG_C: operand = trace.regs_in.c;
            `Z80_REG_D: operand = trace.regs_in.d;
            `Z80_REG_E: operand = trace.regs_in.e;
            `Z80_REG_H: operand = trace.regs_in.h;
            `Z80_REG_L: operand = trace.regs_in.l;
            default:    operand = 8'h00;
        endcase
    end

    assign carry_in   = ((op == `Z80_ALU_ADC) || (op == `Z80_ALU_SBC)) &&
                        trace.regs_in.f[`Z80_FLAG_C_BIT];
    assign is_sub     = (op == `Z80_ALU_SUB) || (op == `Z80_ALU_SBC) || (op == `Z80_ALU_CP);
    assign is_logical = (op == `Z80_ALU_AND) || (op == `Z80_ALU_XOR) || (op == `Z80_ALU_OR);

    // bit 8 and bit 4 give carry or borrow directly.
    assign wide = is_sub ? ({1'b0, a_in} - {1'b0, operand} - {8'd0, carry_in}) :
                           ({1'b0, a_in} + {1'b0, operand} + {8'd0, carry_in});
    assign half = is_sub ? ({1'b0, a_in[3:0]} - {1'b0, operand[3:0]} - {4'd0, carry_in}) :
                           ({1'b0, a_in[3:0]} + {1'b0, operand[3:0]} + {4'd0, carry_in});

    always_comb begin
        case (op)
            `Z80_ALU_AND: result = a_in & operand;
            `Z80_ALU_XOR: result = a_in ^ operand;
            `Z80_ALU_OR:  result = a_in | operand;
            default:      result = wide[7:0];
        endcase
    end

    // signed overflow; parity (even = 1) for logical ops.
    assign flag_v = is_logical ? ~^result :
                    is_sub ? ((a_in[7] != operand[7]) && (result[7] != a_in[7])) :
                             ((a_in[7] == operand[7]) && (result[7] != a_in[7]));

    always_comb begin
        spec.valid  = trace_valid && (trace.insn[7:6] == 2'b10) && (r != `Z80_REG_M);
        spec.a_out  = (op == `Z80_ALU_CP) ? a_in : result;
        spec.ip_out = trace.regs_in.ip + 16'd1;
        spec.f_out                  = 8'h00;
        spec.f_out[`Z80_FLAG_S_BIT] = result[7];
        spec.f_out[`Z80_FLAG_Z_BIT] = (result == 8'h00);
        spec.f_out[`Z80_FLAG_5_BIT] = trace.regs_in.f[`Z80_FLAG_5_BIT];
        spec.f_out[`Z80_FLAG_H_BIT] = (op == `Z80_ALU_AND) || (!is_logical && half[4]);
        spec.f_out[`Z80_FLAG_3_BIT] = trace.regs_in.f[`Z80_FLAG_3_BIT];
        spec.f_out[`Z80_FLAG_V_BIT] = flag_v;
        spec.f_out[`Z80_FLAG_N_BIT] = is_sub;
        spec.f_out[`Z80_FLAG_C_BIT] = !is_logical && wide[8];
    end

endmodule

// File: src/z80fi_retire_monitor.sv
//////////////////////////////////////////////////////////////////////
// both counters saturate at all ones.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "z80_consts.svh"

module z80fi_retire_monitor (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  trace_valid,
    input  z80_pkg::trace_t       trace,
    input  z80_pkg::spec_t        spec,
    output logic [`Z80_CNT_W-1:0] order,
    output logic [`Z80_CNT_W-1:0] retire_count,
    output logic [`Z80_CNT_W-1:0] mismatch_count
);
    import z80_pkg::*;

    logic mismatch;

    assign mismatch = trace_valid &&
                      (!spec.valid ||
                       (trace.a_out != spec.a_out) ||
                       (trace.f_out != spec.f_out) ||
                       (trace.ip_out != spec.ip_out));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_count   <= '0;
            mismatch_count <= '0;
        end else begin
            if (trace_valid && (retire_count != '1)) begin
                retire_count <= retire_count + 1'b1;
            end
            if (mismatch && (mismatch_count != '1)) begin
                mismatch_count <= mismatch_count + 1'b1;
            end
        end
    end

    // current count numbers the instruction now retiring.
    assign order = retire_count;

endmodule

// File: src/z80_core_top.sv
//////////////////////////////////////////////////////////////////////
// ALU A,r core with read-only fetch port and z80fi-style trace.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "z80_consts.svh"

module z80_core_top (
    input  logic                  clk,
    input  logic                  rst_n,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic [15:0]           wb_adr,
    input  logic [7:0]            wb_dat,
    input  logic                  wb_ack,
    output logic                  halted,
    output logic                  trace_valid,
    output z80_pkg::trace_t       trace,
    output logic [`Z80_CNT_W-1:0] retire_count,
    output logic [`Z80_CNT_W-1:0] mismatch_count
);
    import z80_pkg::*;

    regs_t                 regs;
    logic [7:0]            insn;
    logic [7:0]            operand;
    logic [7:0]            alu_result;
    logic [7:0]            alu_flags;
    logic [15:0]           ip;
    logic                  commit;
    alu_func_e             alu_op;
    spec_t                 spec;
    logic [`Z80_CNT_W-1:0] order;

    assign alu_op = alu_func_e'(insn[5:3]);

    z80_seq_fsm i_seq (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_cyc (wb_cyc),
        .wb_stb (wb_stb),
        .wb_adr (wb_adr),
        .wb_dat (wb_dat),
        .wb_ack (wb_ack),
        .ip     (ip),
        .insn   (insn),
        .commit (commit),
        .halted (halted)
    );

    z80_regfile i_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .insn        (insn),
        .commit      (commit),
        .alu_result  (alu_result),
        .alu_flags   (alu_flags),
        .regs        (regs),
        .operand     (operand),
        .ip          (ip),
        .trace_valid (trace_valid),
        .trace       (trace),
        .order       (order)
    );

    z80_alu i_alu (
        .op      (alu_op),
        .a       (regs.a),
        .operand (operand),
        .f_in    (regs.f),
        .result  (alu_result),
        .f_out   (alu_flags)
    );

    z80fi_insn_spec_alu_a_reg i_spec (
        .trace_valid (trace_valid),
        .trace       (trace),
        .spec        (spec)
    );

    z80fi_retire_monitor i_mon (
        .clk            (clk),
        .rst_n          (rst_n),
        .trace_valid    (trace_valid),
        .trace          (trace),
        .spec           (spec),
        .order          (order),
        .retire_count   (retire_count),
        .mismatch_count (mismatch_count)
    );

endmodule

// File: tb/z80_core_chk.sv
//////////////////////////////////////////////////////////////////////
// bus and trace timing checks, bound into z80_core_top.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module z80_core_chk (
    input logic        clk,
    input logic        rst_n,
    input logic        wb_cyc,
    input logic        wb_stb,
    input logic [15:0] wb_adr,
    input logic        wb_ack,
    input logic        trace_valid,
    input logic        halted
);
    int error_count;

    initial begin
        error_count = 0;
    end

    stb_needs_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb |-> wb_cyc)
    else begin
        error_count = error_count + 1;
        $error("wb_stb high without wb_cyc");
    end

    // request holds until acknowledged.
    adr_held: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)))
    else begin
        error_count = error_count + 1;
        $error("wb_stb dropped or wb_adr changed before wb_ack");
    end

    trace_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        trace_valid |-> $past(wb_cyc && wb_ack))
    else begin
        error_count = error_count + 1;
        $error("trace_valid not one cycle after wb_ack");
    end

    trace_single: assert property (@(posedge clk) disable iff (!rst_n)
        trace_valid |=> !trace_valid)
    else begin
        error_count = error_count + 1;
        $error("trace_valid longer than one cycle");
    end

    no_fetch_halted: assert property (@(posedge clk) disable iff (!rst_n)
        !(halted && wb_cyc))
    else begin
        error_count = error_count + 1;
        $error("wb_cyc high while halted");
    end

endmodule

bind z80_core_top z80_core_chk i_chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_adr      (wb_adr),
    .wb_ack      (wb_ack),
    .trace_valid (trace_valid),
    .halted      (halted)
);

// File: tb/z80_core_tb.sv
//////////////////////////////////////////////////////////////////////
// runs tb/alu_patterns.hex from the project root; stops at first error.
// memory answers with 0 to 3 random wait states.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "z80_consts.svh"

module z80_core_tb;
    import z80_pkg::*;

    localparam int MAX_PATTERNS = 64;
    localparam int DRIVE_DLY    = 1;
    localparam int RESET_CYCLES = 10;
    localparam int HALT_CYCLES  = 20;

    logic                  clk;
    logic                  rst_n;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic [15:0]           wb_adr;
    logic [7:0]            wb_dat;
    logic                  wb_ack;
    logic                  halted;
    logic                  trace_valid;
    trace_t                trace;
    logic [`Z80_CNT_W-1:0] retire_count;
    logic [`Z80_CNT_W-1:0] mismatch_count;

    logic [7:0] patterns [0:3*MAX_PATTERNS-1];
    logic [7:0] mem_image [0:65535];
    int         legal_count;
    int         pattern_count;

    z80_core_top i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_adr         (wb_adr),
        .wb_dat         (wb_dat),
        .wb_ack         (wb_ack),
        .halted         (halted),
        .trace_valid    (trace_valid),
        .trace          (trace),
        .retire_count   (retire_count),
        .mismatch_count (mismatch_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic value_error(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        fail_run($sformatf("ERROR %s: expected %0h, actual %0h", name, expected, actual));
    endtask

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [7:0] fill_byte(input int addr);
        logic [15:0] a;
        a = addr[15:0];
        return a[15:8] ^ a[7:0] ^ 8'h5a;
    endfunction

    // group 10 ooo rrr without the memory operand.
    function automatic bit is_alu_a_reg(input logic [7:0] op);
        return (op[7:6] == 2'b10) && (op[2:0] != `Z80_REG_M);
    endfunction

    task automatic load_patterns();
        int a;
        int k;
        $readmemh("tb/alu_patterns.hex", patterns);
        legal_count = 0;
        while ((legal_count < MAX_PATTERNS) && is_alu_a_reg(patterns[3*legal_count])) begin
            legal_count++;
        end
        assert (legal_count < MAX_PATTERNS)
        else fail_run("pattern file does not end with an illegal opcode");
        for (a = 0; a < 65536; a++) begin
            mem_image[a] = fill_byte(a);
        end
        for (k = 0; k <= legal_count; k++) begin
            mem_image[k] = patterns[3*k];
        end
        pattern_count = legal_count + 1;
    endtask

    task automatic wait_retire(input int idx);
        @(negedge clk);
        while (!trace_valid) begin
            assert (!halted)
            else fail_run($sformatf("core halted before pattern %0d retired", idx));
            @(negedge clk);
        end
    endtask

    // prev_a and prev_f are the values left by the previous pattern.
    task automatic check_retire(input int idx, input logic [7:0] prev_a,
                                input logic [7:0] prev_f);
        logic [7:0] opcode;
        logic [7:0] exp_a;
        logic [7:0] exp_f;
        opcode = patterns[3*idx];
        exp_a  = patterns[3*idx+1];
        exp_f  = patterns[3*idx+2];
        assert (trace.insn == opcode)
        else value_error($sformatf("insn[%0d]", idx), opcode, trace.insn);
        assert (trace.regs_in.a == prev_a)
        else value_error($sformatf("a_in[%0d]", idx), prev_a, trace.regs_in.a);
        assert (trace.regs_in.f == prev_f)
        else value_error($sformatf("f_in[%0d]", idx), prev_f, trace.regs_in.f);
        assert (trace.a_out == exp_a)
        else value_error($sformatf("a_out[%0d]", idx), exp_a, trace.a_out);
        assert (trace.f_out == exp_f)
        else value_error($sformatf("f_out[%0d]", idx), exp_f, trace.f_out);
        if (opcode[5:3] == `Z80_ALU_CP) begin
            assert (trace.a_out == prev_a)
            else value_error($sformatf("cp_keeps_a[%0d]", idx), prev_a, trace.a_out);
        end
        assert (trace.regs_in.ip == idx)
        else value_error($sformatf("ip_in[%0d]", idx), idx, trace.regs_in.ip);
        assert (trace.ip_out == idx + 1)
        else value_error($sformatf("ip_out[%0d]", idx), idx + 1, trace.ip_out);
        assert (trace.order == idx)
        else value_error($sformatf("order[%0d]", idx), idx, trace.order);
        assert (retire_count == idx)
        else value_error($sformatf("retire_count[%0d]", idx), idx, retire_count);
        assert (mismatch_count == 0)
        else value_error($sformatf("mismatch_count[%0d]", idx), 0, mismatch_count);
    endtask

    ////////////////////////////////////////////////////////////////////
    // wishbone memory model
    ////////////////////////////////////////////////////////////////////
    initial begin : memory_model
        int          waits_left;
        int          fetch_index;
        logic [31:0] lcg_state;
        wb_ack      = 1'b0;
        wb_dat      = 8'h00;
        waits_left  = -1;
        fetch_index = 0;
        lcg_state   = 32'd96;
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            if (wb_ack) begin
                wb_ack = 1'b0;
                fetch_index++;
            end else if (wb_cyc) begin
                if (waits_left < 0) begin
                    lcg_state  = lcg_step(lcg_state);
                    waits_left = lcg_state[17:16];
                end
                assert (wb_stb) else fail_run("wb_stb low during a bus cycle");
                assert (wb_adr == fetch_index)
                else value_error("wb_adr", fetch_index, wb_adr);
                if (waits_left == 0) begin
                    wb_ack     = 1'b1;
                    wb_dat     = mem_image[wb_adr];
                    waits_left = -1;
                end else begin
                    waits_left--;
                end
            end else begin
                assert (waits_left < 0) else fail_run("wb_cyc dropped before wb_ack");
            end
        end
    end

    // generous bound of six cycles per pattern.
    initial begin : watchdog
        wait (pattern_count != 0);
        repeat (pattern_count * 6 + 50) @(posedge clk);
        fail_run("watchdog expired before the core halted");
    end

    initial begin : bound_check_watch
        wait (i_dut.i_chk.error_count != 0);
        fail_run("bound bus or trace assertion failed");
    end

    ////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////
    initial begin : main_seq
        int         i;
        logic [7:0] prev_a;
        logic [7:0] prev_f;
        rst_n = 1'b0;
        load_patterns();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        assert (!wb_cyc && !wb_stb && !halted && !trace_valid)
        else fail_run("bus, halt or trace output active during reset");
        assert (retire_count == 0)
        else value_error("reset_retire_count", 0, retire_count);
        assert (mismatch_count == 0)
        else value_error("reset_mismatch_count", 0, mismatch_count);
        rst_n = 1'b1;
        prev_a = `Z80_RESET_A;
        prev_f = `Z80_RESET_F;
        for (i = 0; i < legal_count; i++) begin
            wait_retire(i);
            check_retire(i, prev_a, prev_f);
            prev_a = patterns[3*i+1];
            prev_f = patterns[3*i+2];
        end
        // illegal opcode comes next.
        while (!halted) begin
            @(negedge clk);
            assert (!trace_valid) else fail_run("trace_valid while fetching the illegal opcode");
        end
        repeat (HALT_CYCLES) begin
            @(negedge clk);
            assert (!trace_valid) else fail_run("trace_valid after the core halted");
            assert (halted) else fail_run("halted dropped without reset");
        end
        assert (retire_count == legal_count)
        else value_error("final_retire_count", legal_count, retire_count);
        assert (mismatch_count == 0)
        else value_error("final_mismatch_count", 0, mismatch_count);
        $display("test passed");
        $finish;
    end

endmodule

// File: tb.f
+incdir+src
src/z80_pkg.sv
src/z80_seq_fsm.sv
src/z80_regfile.sv
src/z80_alu.sv
src/z80fi_insn_spec_alu_a_reg.sv
src/z80fi_retire_monitor.sv
src/z80_core_top.sv
tb/z80_core_chk.sv
tb/z80_core_tb.sv

// File: tb/alu_patterns.hex
// columns: opcode, expected A after it, expected F after it (hex bytes)
// legal ALU A,r opcodes in fetch order; the last line is illegal and halts the core.
80 3c 00 // add a,b
84 bb 94 // add a,h
85 ba 91 // add a,l
8a bc 80 // adc a,d
8b 3c 05 // adc a,e
88 79 10 // adc a,b
90 3d 12 // sub b
91 96 87 // sub c
9a 94 82 // sbc a,d
9b 14 02 // sbc a,e
97 00 42 // sub a
9d 01 13 // sbc a,l
9a ff 93 // sbc a,d
a1 a7 90 // and c
a0 24 14 // and b
af 00 44 // xor a
b3 80 80 // or e
b0 bc 80 // or b
ac c3 84 // xor h
b9 c3 12 // cp c
bf c3 42 // cp a
bd c3 93 // cp l
83 43 05 // add a,e
86 00 00 // add a,(hl)
